// ==== source/nds32Pkg.sv ====
package nds32Pkg;

  // register form, three registers plus a sub-opcode
  typedef struct packed {
    logic       zero;
    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rsvd;
    logic [4:0] subOp;
  } regFmt_t;

  // immediate form, wider immediates reach down into ra
  typedef struct packed {
    logic        zero;
    logic [5:0]  opcode;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [14:0] imm;
  } immFmt_t;

  typedef union packed {
    regFmt_t regFmt;
    immFmt_t immFmt;
  } instr_t;

  typedef enum logic [2:0] {immNone, imm5, imm15, imm20, imm14, imm24} immSel_t;

  typedef enum logic [3:0] {
    fnAdd, fnSub, fnAnd, fnOr, fnXor, fnSll, fnSrl, fnRotr, fnPassB
  } aluFn_t;

  typedef struct packed {
    logic    regDst;   // rb is second source
    logic    branch;
    logic    jump;
    logic    memRead;
    logic    memToReg;
    logic    memWrite;
    logic    aluSrc;   // immediate on operand b
    logic    regWrite;
    immSel_t immSel;
    aluFn_t  aluFn;
  } ctrlWord_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;  // byte address
    logic [31:0] wdata;
  } memReq_t;

  typedef struct packed {
    logic        done;  // one-cycle pulse
    logic [31:0] rdata;
  } memRsp_t;

  localparam logic [5:0] opAlu  = 6'b100000;
  localparam logic [5:0] opAddi = 6'b101000;
  localparam logic [5:0] opOri  = 6'b101100;
  localparam logic [5:0] opXori = 6'b101011;
  localparam logic [5:0] opLwi  = 6'b000010;
  localparam logic [5:0] opSwi  = 6'b001010;
  localparam logic [5:0] opMovi = 6'b100010;
  localparam logic [5:0] opMem  = 6'b011100;
  localparam logic [5:0] opBeq  = 6'b100110;
  localparam logic [5:0] opJ    = 6'b100100;

  localparam logic [4:0] subAdd   = 5'b00000;
  localparam logic [4:0] subSub   = 5'b00001;
  localparam logic [4:0] subAnd   = 5'b00010;
  localparam logic [4:0] subXor   = 5'b00011;
  localparam logic [4:0] subOr    = 5'b00100;
  localparam logic [4:0] subSlli  = 5'b01000;
  localparam logic [4:0] subSrli  = 5'b01001;
  localparam logic [4:0] subRotri = 5'b01011;
  localparam logic [4:0] subLw    = 5'b00010;
  localparam logic [4:0] subSw    = 5'b01010;

endpackage

// ==== source/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder (
  input  nds32Pkg::instr_t    instr,
  output nds32Pkg::ctrlWord_t ctrl,
  output logic                illegal
);
  import nds32Pkg::*;

  always_comb begin
    ctrl    = '0;
    illegal = 1'b0;
    case (instr.regFmt.opcode)
      opAlu: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (instr.regFmt.subOp)
          subAdd:   ctrl.aluFn = fnAdd;
          subSub:   ctrl.aluFn = fnSub;
          subAnd:   ctrl.aluFn = fnAnd;
          subXor:   ctrl.aluFn = fnXor;
          subOr:    ctrl.aluFn = fnOr;
          subSlli:  ctrl.aluFn = fnSll;
          subSrli:  ctrl.aluFn = fnSrl;
          subRotri: ctrl.aluFn = fnRotr;
          default: begin
            ctrl.regWrite = 1'b0;   // unknown sub-op
            ctrl.regDst   = 1'b0;
            illegal       = 1'b1;
          end
        endcase
        if (ctrl.aluFn inside {fnSll, fnSrl, fnRotr}) begin
          ctrl.immSel = imm5;       // shift amount sits in rb field
          ctrl.regDst = 1'b0;
          ctrl.aluSrc = 1'b1;
        end
      end
      opAddi, opOri, opXori: begin
        ctrl.immSel   = imm15;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        if (instr.regFmt.opcode == opAddi) ctrl.aluFn = fnAdd;
        else if (instr.regFmt.opcode == opOri) ctrl.aluFn = fnOr;
        else ctrl.aluFn = fnXor;
      end
      opLwi: begin
        ctrl.immSel   = imm15;
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opSwi: begin
        ctrl.immSel   = imm15;
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      opMovi: begin
        ctrl.immSel   = imm20;
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluFn    = fnPassB;
      end
      opMem: begin
        case (instr.regFmt.subOp)
          subLw: begin
            ctrl.memRead  = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.regWrite = 1'b1;
          end
          subSw: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end
      opBeq: begin
        ctrl.immSel = imm14;
        ctrl.branch = 1'b1;         // compares ra with rt
        ctrl.aluFn  = fnSub;
      end
      opJ: begin
        ctrl.immSel = imm24;
        ctrl.branch = 1'b1;
        ctrl.jump   = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        rstN,
  input  logic [4:0]  raAddr,
  input  logic [4:0]  rbAddr,
  output logic [31:0] raData,
  output logic [31:0] rbData,
  input  logic        we,
  input  logic [4:0]  wAddr,
  input  logic [31:0] wData
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wAddr] <= wData;
    end
  end

  // reads see the old value during a write cycle
  assign raData = regs[raAddr];
  assign rbData = regs[rbAddr];

endmodule

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
  input  nds32Pkg::aluFn_t fn,
  input  logic [31:0]      a,
  input  logic [31:0]      b,
  output logic [31:0]      y,
  output logic             equal
);
  import nds32Pkg::*;

  logic [4:0]  shAmt;
  logic [63:0] rotWide;

  assign shAmt   = b[4:0];
  assign rotWide = {a, a} >> shAmt;  // low half is the rotated word
  assign equal   = (a == b);         // branch compare

  always_comb begin
    case (fn)
      fnAdd:   y = a + b;
      fnSub:   y = a - b;
      fnAnd:   y = a & b;
      fnOr:    y = a | b;
      fnXor:   y = a ^ b;
      fnSll:   y = a << shAmt;
      fnSrl:   y = a >> shAmt;
      fnRotr:  y = rotWide[31:0];
      fnPassB: y = b;               // movi
      default: y = '0;
    endcase
  end

endmodule

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              run,
  output nds32Pkg::memReq_t memReq,
  input  nds32Pkg::memRsp_t memRsp,
  output nds32Pkg::instr_t  instr,
  output logic              instrValid,
  output logic [31:0]       pc,
  input  logic              stepDone,
  input  logic              takeBranch,
  input  logic [31:0]       branchOffset,
  input  logic              illegal,
  output logic              halted,
  output logic              fault
);
  import nds32Pkg::*;

  typedef enum logic [1:0] {sFetch, sStep, sStop} state_t;

  state_t      state;
  logic        started;
  logic        stopNow;
  logic [31:0] nextPc;

  assign nextPc  = takeBranch ? pc + branchOffset : pc + 32'd4;
  assign stopNow = illegal || (takeBranch && branchOffset == '0);  // jump to self halts

  assign memReq.valid = (state == sFetch) && (run || started);
  assign memReq.write = 1'b0;
  assign memReq.addr  = pc;
  assign memReq.wdata = '0;
  assign halted       = (state == sStop);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state      <= sFetch;
      started    <= 1'b0;
      pc         <= '0;
      instrValid <= 1'b0;
      fault      <= 1'b0;
    end else begin
      instrValid <= 1'b0;
      if (run) started <= 1'b1;       // keeps a fetch alive once begun
      case (state)
        sFetch: begin
          if (memRsp.done) begin
            state      <= sStep;
            instrValid <= 1'b1;
          end
        end
        sStep: begin
          if (stepDone) begin
            pc    <= nextPc;
            fault <= illegal;
            state <= stopNow ? sStop : sFetch;
          end
        end
        default: state <= sStop;      // stays until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == sFetch && memRsp.done) instr <= memRsp.rdata;
  end

endmodule

// ==== source/loadStoreUnit.sv ====
`timescale 1ns/1ps

module loadStoreUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              start,
  input  logic              write,
  input  logic [31:0]       addr,
  input  logic [31:0]       wdata,
  output nds32Pkg::memReq_t memReq,
  input  nds32Pkg::memRsp_t memRsp,
  output logic [31:0]       rdata,
  output logic              done
);
  import nds32Pkg::*;

  logic        busy;
  logic        wrQ;
  logic [31:0] addrQ;
  logic [31:0] wdataQ;

  assign memReq.valid = busy;   // held until the response
  assign memReq.write = wrQ;
  assign memReq.addr  = addrQ;
  assign memReq.wdata = wdataQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= busy && memRsp.done;
      if (start) busy <= 1'b1;
      else if (memRsp.done) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      wrQ    <= write;
      addrQ  <= addr;
      wdataQ <= wdata;
    end
    if (busy && memRsp.done) rdata <= memRsp.rdata;  // ready with done
  end

  // the core issues one access per instruction and waits for it
  assert property (@(posedge clk) disable iff (!rstN) start |-> !busy);

endmodule

// ==== source/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
  input  logic              clk,
  input  logic              rstN,
  input  nds32Pkg::memReq_t hostReq,
  input  nds32Pkg::memReq_t lsuReq,
  input  nds32Pkg::memReq_t fetchReq,
  output nds32Pkg::memRsp_t hostRsp,
  output nds32Pkg::memRsp_t lsuRsp,
  output nds32Pkg::memRsp_t fetchRsp,
  output nds32Pkg::memReq_t memReq,
  input  nds32Pkg::memRsp_t memRsp
);
  import nds32Pkg::*;

  localparam logic [1:0] ownHost  = 2'd0;
  localparam logic [1:0] ownLsu   = 2'd1;
  localparam logic [1:0] ownFetch = 2'd2;

  logic       pending;   // response due this cycle
  logic [1:0] owner;
  logic [1:0] pick;

  always_comb begin
    pick   = ownFetch;
    memReq = fetchReq;
    if (hostReq.valid) begin
      pick   = ownHost;
      memReq = hostReq;
    end else if (lsuReq.valid) begin
      pick   = ownLsu;
      memReq = lsuReq;
    end
    memReq.valid = memReq.valid && !pending;  // one access in flight
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pending <= 1'b0;
      owner   <= ownHost;
    end else begin
      pending <= memReq.valid;
      if (memReq.valid) owner <= pick;
    end
  end

  assign hostRsp  = '{done: pending && owner == ownHost && memRsp.done, rdata: memRsp.rdata};
  assign lsuRsp   = '{done: pending && owner == ownLsu && memRsp.done, rdata: memRsp.rdata};
  assign fetchRsp = '{done: pending && owner == ownFetch && memRsp.done, rdata: memRsp.rdata};

  // memory answers every grant exactly one cycle later
  assert property (@(posedge clk) disable iff (!rstN) memReq.valid |=> memRsp.done);

endmodule

// ==== source/sharedMemory.sv ====
`timescale 1ns/1ps

module sharedMemory #(
  parameter int memWords = 1024
) (
  input  logic              clk,
  input  nds32Pkg::memReq_t req,
  output nds32Pkg::memRsp_t rsp
);
  import nds32Pkg::*;

  localparam int idxW = $clog2(memWords);

  logic [31:0]     mem [memWords];
  logic [idxW-1:0] idx;

  assign idx = req.addr[idxW+1:2];  // word index, upper bits wrap

  always_ff @(posedge clk) begin
    rsp.done <= req.valid;
    if (req.valid) begin
      if (req.write) begin
        mem[idx] <= req.wdata;
      end
      rsp.rdata <= mem[idx];        // old word on a write
    end
  end

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
  parameter int memWords = 1024
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              run,
  input  nds32Pkg::memReq_t hostReq,
  output nds32Pkg::memRsp_t hostRsp,
  output logic              halted,
  output logic              fault
);
  import nds32Pkg::*;

  memReq_t     fetchReq, lsuReq, memReq;
  memRsp_t     fetchRsp, lsuRsp, memRsp;
  instr_t      instr;
  ctrlWord_t   ctrl;
  logic        instrValid, illegal, equal, takeBranch, stepDone;
  logic        memOp, useRb, regWe, lsuStart, lsuDone;
  logic [4:0]  rbAddr;
  logic [31:0] pc, immExt, raData, rbData, aluB, aluY;
  logic [31:0] effAddr, addrQ, lsuRdata, wData;

  always_comb begin
    case (ctrl.immSel)
      imm5:    immExt = {27'd0, instr.regFmt.rb};
      imm15:   immExt = {{17{instr.immFmt.imm[14]}}, instr.immFmt.imm};
      imm20:   immExt = {{12{instr[19]}}, instr[19:0]};
      imm14:   immExt = {{16{instr[13]}}, instr[13:0], 2'b00};  // word offset
      imm24:   immExt = {{6{instr[23]}}, instr[23:0], 2'b00};
      default: immExt = '0;
    endcase
  end

  // register-form accesses read rb for the address, then rt for store data
  assign memOp   = ctrl.memRead | ctrl.memWrite;
  assign useRb   = ctrl.regDst || (memOp && ctrl.immSel == immNone && instrValid);
  assign rbAddr  = useRb ? instr.regFmt.rb : instr.regFmt.rt;
  assign aluB    = ctrl.aluSrc ? immExt : rbData;
  assign effAddr = raData + ((ctrl.immSel == immNone) ? rbData : {immExt[29:0], 2'b00});

  assign regWe      = ctrl.regWrite && (ctrl.memToReg ? lsuDone : instrValid);
  assign wData      = ctrl.memToReg ? lsuRdata : aluY;
  assign takeBranch = ctrl.jump || (ctrl.branch && equal);
  assign stepDone   = (instrValid && !memOp) || lsuDone;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) lsuStart <= 1'b0;
    else lsuStart <= instrValid && memOp;  // second execute cycle
  end

  always_ff @(posedge clk) begin
    if (instrValid && memOp) addrQ <= effAddr;
  end

  fetchUnit uFetch (.clk, .rstN, .run, .memReq(fetchReq), .memRsp(fetchRsp), .instr,
    .instrValid, .pc, .stepDone, .takeBranch, .branchOffset(immExt), .illegal, .halted, .fault);

  controlDecoder uDec (.instr, .ctrl, .illegal);

  regFile uRegs (.clk, .rstN, .raAddr(instr.regFmt.ra), .rbAddr, .raData, .rbData,
    .we(regWe), .wAddr(instr.regFmt.rt), .wData);

  aluUnit uAlu (.fn(ctrl.aluFn), .a(raData), .b(aluB), .y(aluY), .equal);

  loadStoreUnit uLsu (.clk, .rstN, .start(lsuStart), .write(ctrl.memWrite), .addr(addrQ),
    .wdata(rbData), .memReq(lsuReq), .memRsp(lsuRsp), .rdata(lsuRdata), .done(lsuDone));

  memArbiter uArb (.clk, .rstN, .hostReq, .lsuReq, .fetchReq, .hostRsp, .lsuRsp, .fetchRsp,
    .memReq, .memRsp);

  sharedMemory #(.memWords(memWords)) uMem (.clk, .req(memReq), .rsp(memRsp));

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
  parameter int periodNs    = 100,
  parameter int resetCycles = 10
) (
  input  logic resetReq,   // rising edge starts another reset
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    forever begin
      repeat (resetCycles) @(posedge clk);
      #5;
      rstN = 1'b1;   // released with the stimulus
      @(posedge resetReq);
      rstN = 1'b0;
    end
  end

endmodule

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
  import nds32Pkg::*;

  localparam int numRows    = 5;
  localparam int progWords  = 12;
  localparam int dataWords  = 4;
  localparam int resWords   = 4;
  localparam int hostLimit  = 50;    // cycles per host access
  localparam int haltLimit  = 2000;
  localparam int resetLimit = 40;
  localparam logic [31:0] dataBase = 32'h100;
  localparam logic [31:0] resBase  = 32'h200;

  logic    clk;
  logic    rstN;
  logic    resetReq;
  logic    run;
  memReq_t hostReq;
  memRsp_t hostRsp;
  logic    halted;
  logic    fault;

  string       rowName  [numRows];
  logic [31:0] progTab  [numRows][progWords];   // loaded at address 0
  logic [31:0] dataTab  [numRows][dataWords];   // loaded at dataBase
  logic [31:0] expTab   [numRows][resWords];    // expected at resBase
  logic        expFault [numRows];
  int          row;

  clockGen #(.periodNs(100), .resetCycles(10)) clkGen (.resetReq, .clk, .rstN);

  cpuTop #(.memWords(1024)) uut (.clk, .rstN, .run, .hostReq, .hostRsp, .halted, .fault);

  function automatic logic [31:0] regInstr(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
                                           logic [4:0] rb, logic [4:0] sub);
    return {1'b0, op, rt, ra, rb, 5'd0, sub};
  endfunction

  function automatic logic [31:0] immInstr(logic [5:0] op, logic [4:0] rt, logic [4:0] ra,
                                           logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic logic [31:0] moviInstr(logic [4:0] rt, logic [19:0] imm);
    return {1'b0, opMovi, rt, imm};
  endfunction

  function automatic logic [31:0] beqInstr(logic [4:0] rt, logic [4:0] ra, logic [13:0] off);
    return {1'b0, opBeq, rt, ra, 1'b0, off};   // off counts words
  endfunction

  function automatic logic [31:0] jumpInstr(logic [23:0] off);
    return {1'b0, opJ, 1'b0, off};
  endfunction

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkWord(input memRsp_t rsp, input logic [31:0] expected, input string what);
    if (rsp.rdata !== expected) begin
      abortRun($sformatf("Error at %0t ns: row %s, %s read %08h, expected %08h",
                         $time, rowName[row], what, rsp.rdata, expected));
    end
  endtask

  task automatic checkStatus(input logic haltedNow, input logic faultNow,
                             input logic haltedExp, input logic faultExp);
    if (haltedNow !== haltedExp || faultNow !== faultExp) begin
      abortRun($sformatf("Error at %0t ns: row %s, halted %b fault %b, expected %b and %b",
                         $time, rowName[row], haltedNow, faultNow, haltedExp, faultExp));
    end
  endtask

  // called at the stimulus offset and holds the request until done
  task automatic hostAccess(input logic isWrite, input logic [31:0] addr,
                            input logic [31:0] wdata, output memRsp_t rsp);
    int cycles;
    cycles        = 0;
    hostReq.valid = 1'b1;
    hostReq.write = isWrite;
    hostReq.addr  = addr;
    hostReq.wdata = wdata;
    do begin
      @(posedge clk);
      #5;
      cycles++;
      if (cycles > hostLimit) begin
        abortRun($sformatf("Host access to address %08h got no response in %0d cycles",
                           addr, hostLimit));
      end
    end while (hostRsp.done !== 1'b1);
    rsp     = hostRsp;
    hostReq = '0;
  endtask

  task automatic waitReset();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > resetLimit) abortRun("Reset was never released");
    end while (rstN !== 1'b1);
    #5;   // back to the stimulus offset
  endtask

  task automatic pulseReset();
    run      = 1'b0;
    resetReq = 1'b1;
    @(posedge clk);
    #5;
    resetReq = 1'b0;
    waitReset();
  endtask

  task automatic waitHalt();
    int cycles;
    cycles = 0;
    while (halted !== 1'b1) begin
      @(posedge clk);
      #5;
      cycles++;
      if (cycles > haltLimit) begin
        abortRun($sformatf("Core did not halt within %0d cycles in row %s",
                           haltLimit, rowName[row]));
      end
    end
  endtask

  task automatic buildTable();
    logic [31:0] sh;
    for (int r = 0; r < numRows; r++) begin
      for (int i = 0; i < progWords; i++) progTab[r][i] = '0;
      for (int i = 0; i < dataWords; i++) dataTab[r][i] = $urandom;
      for (int i = 0; i < resWords; i++) expTab[r][i] = '0;
      expFault[r] = 1'b0;
    end

    rowName[0]     = "aluReg";
    progTab[0][0]  = immInstr(opLwi, 1, 0, 15'h040);
    progTab[0][1]  = immInstr(opLwi, 2, 0, 15'h041);
    progTab[0][2]  = regInstr(opAlu, 3, 1, 2, subAdd);
    progTab[0][3]  = regInstr(opAlu, 4, 1, 2, subSub);
    progTab[0][4]  = regInstr(opAlu, 5, 1, 2, subAnd);
    progTab[0][5]  = regInstr(opAlu, 6, 1, 2, subOr);
    progTab[0][6]  = regInstr(opAlu, 6, 6, 5, subXor);
    progTab[0][7]  = immInstr(opSwi, 3, 0, 15'h080);
    progTab[0][8]  = immInstr(opSwi, 4, 0, 15'h081);
    progTab[0][9]  = immInstr(opSwi, 5, 0, 15'h082);
    progTab[0][10] = immInstr(opSwi, 6, 0, 15'h083);
    progTab[0][11] = jumpInstr(24'd0);
    expTab[0][0]   = dataTab[0][0] + dataTab[0][1];
    expTab[0][1]   = dataTab[0][0] - dataTab[0][1];
    expTab[0][2]   = dataTab[0][0] & dataTab[0][1];
    expTab[0][3]   = (dataTab[0][0] | dataTab[0][1]) ^ (dataTab[0][0] & dataTab[0][1]);

    rowName[1]     = "immediates";
    progTab[1][0]  = immInstr(opLwi, 1, 0, 15'h040);
    progTab[1][1]  = immInstr(opAddi, 2, 1, 15'h7ff0);   // minus 16
    progTab[1][2]  = immInstr(opXori, 2, 2, 15'h4321);
    progTab[1][3]  = immInstr(opOri, 3, 1, 15'h4005);
    progTab[1][4]  = regInstr(opAlu, 4, 1, 7, subSlli);
    progTab[1][5]  = regInstr(opAlu, 5, 1, 13, subSrli);
    progTab[1][6]  = regInstr(opAlu, 5, 5, 9, subRotri);
    progTab[1][7]  = immInstr(opSwi, 2, 0, 15'h080);
    progTab[1][8]  = immInstr(opSwi, 3, 0, 15'h081);
    progTab[1][9]  = immInstr(opSwi, 4, 0, 15'h082);
    progTab[1][10] = immInstr(opSwi, 5, 0, 15'h083);
    progTab[1][11] = jumpInstr(24'd0);
    sh             = dataTab[1][0] >> 13;
    expTab[1][0]   = (dataTab[1][0] - 32'd16) ^ 32'hffff_c321;   // imm15 sign-extended
    expTab[1][1]   = dataTab[1][0] | 32'hffff_c005;
    expTab[1][2]   = dataTab[1][0] << 7;
    expTab[1][3]   = {sh[8:0], sh[31:9]};   // rotate right by 9

    rowName[2]     = "loadStore";
    progTab[2][0]  = moviInstr(1, 20'h00100);
    progTab[2][1]  = moviInstr(2, 20'h00008);
    progTab[2][2]  = regInstr(opMem, 3, 1, 2, subLw);
    progTab[2][3]  = immInstr(opLwi, 4, 1, 15'h001);
    progTab[2][4]  = moviInstr(5, 20'h00200);
    progTab[2][5]  = regInstr(opMem, 3, 5, 2, subSw);
    progTab[2][6]  = immInstr(opSwi, 4, 5, 15'h003);
    progTab[2][7]  = moviInstr(6, 20'hfff00);           // negative base
    progTab[2][8]  = immInstr(opLwi, 7, 6, 15'h083);
    progTab[2][9]  = regInstr(opMem, 7, 5, 0, subSw);
    progTab[2][10] = immInstr(opSwi, 6, 5, 15'h001);
    progTab[2][11] = jumpInstr(24'd0);
    expTab[2][0]   = dataTab[2][3];
    expTab[2][1]   = 32'hffff_ff00;
    expTab[2][2]   = dataTab[2][2];
    expTab[2][3]   = dataTab[2][1];

    rowName[3]     = "controlFlow";
    progTab[3][0]  = moviInstr(1, 20'd5);
    progTab[3][1]  = moviInstr(2, 20'd2);
    progTab[3][2]  = immInstr(opAddi, 3, 3, 15'd3);     // loop body
    progTab[3][3]  = immInstr(opAddi, 1, 1, 15'h7fff);
    progTab[3][4]  = beqInstr(2, 1, 14'd2);
    progTab[3][5]  = jumpInstr(24'hfffffd);
    progTab[3][6]  = immInstr(opSwi, 3, 0, 15'h080);
    progTab[3][7]  = immInstr(opSwi, 1, 0, 15'h081);
    progTab[3][8]  = jumpInstr(24'd2);
    progTab[3][9]  = immInstr(opSwi, 1, 0, 15'h082);    // skipped
    progTab[3][10] = jumpInstr(24'd0);
    expTab[3][0]   = 32'd3 * (32'd5 - 32'd2);
    expTab[3][1]   = 32'd2;

    rowName[4]     = "illegalOp";
    progTab[4][0]  = immInstr(opLwi, 1, 0, 15'h040);
    progTab[4][1]  = immInstr(opSwi, 1, 0, 15'h080);
    progTab[4][2]  = 32'h7e00_0000;                      // opcode 111111
    progTab[4][3]  = immInstr(opSwi, 1, 0, 15'h081);
    progTab[4][4]  = jumpInstr(24'd0);
    expTab[4][0]   = dataTab[4][0];
    expFault[4]    = 1'b1;
  endtask

  task automatic runRow(input int r);
    memRsp_t rsp;
    pulseReset();
    checkStatus(halted, fault, 1'b0, 1'b0);
    for (int i = 0; i < progWords; i++) begin
      hostAccess(1'b1, 32'(4 * i), progTab[r][i], rsp);
    end
    for (int i = 0; i < dataWords; i++) begin
      hostAccess(1'b1, dataBase + 32'(4 * i), dataTab[r][i], rsp);
    end
    for (int i = 0; i < resWords; i++) begin
      hostAccess(1'b1, resBase + 32'(4 * i), 32'd0, rsp);
    end
    run = 1'b1;
    // these reads compete with fetch and load/store traffic
    for (int i = 0; i < dataWords; i++) begin
      hostAccess(1'b0, dataBase + 32'(4 * i), 32'd0, rsp);
      checkWord(rsp, dataTab[r][i], $sformatf("data word %0d during run", i));
    end
    waitHalt();
    checkStatus(halted, fault, 1'b1, expFault[r]);
    for (int i = 0; i < resWords; i++) begin
      hostAccess(1'b0, resBase + 32'(4 * i), 32'd0, rsp);
      checkWord(rsp, expTab[r][i], $sformatf("result word %0d", i));
    end
    run = 1'b0;
  endtask

  initial begin
    resetReq = 1'b0;
    run      = 1'b0;
    hostReq  = '0;
    row      = 0;
    void'($urandom(32'h4f3a52ac));
    buildTable();
    waitReset();
    for (row = 0; row < numRows; row++) begin
      runRow(row);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== compile.f ====
source/nds32Pkg.sv
source/controlDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/fetchUnit.sv
source/loadStoreUnit.sv
source/memArbiter.sv
source/sharedMemory.sv
source/cpuTop.sv
dv/clockGen.sv
dv/cpuTb.sv
